/* logic/main_pkg.sv */
package main_pkg;

    // Region an address falls in
    typedef enum logic [2:0] {
        rgn_gfx1,
        rgn_io,
        rgn_pal,
        rgn_gfx2,
        rgn_ram,
        rgn_rom_bank,
        rgn_rom_fix,
        rgn_none
    } mem_region_e;

    // Offsets in the I/O window, named by read source and write target
    typedef enum logic [2:0] {
        reg_sys_snd,
        reg_joy1_irq,
        reg_joy2_vbank,
        reg_dipa_prio,
        reg_dipb_rombank,
        reg_dipc_ack,
        reg_spare6,
        reg_spare7
    } io_reg_e;

    typedef enum logic [1:0] {
        st_idle,
        st_rom_wait,
        st_ack
    } bus_state_e;

    // Memory map
    localparam logic [15:0] GFX1_BASE     = 16'h0000;
    localparam logic [15:0] GFX1_LAST     = 16'h0FFF;
    localparam logic [15:0] IO_BASE       = 16'h1000;
    localparam logic [15:0] IO_LAST       = 16'h10FF;
    localparam logic [15:0] PAL_BASE      = 16'h1800;
    localparam logic [15:0] PAL_LAST      = 16'h18FF;
    localparam logic [15:0] GFX2_BASE     = 16'h2000;
    localparam logic [15:0] GFX2_LAST     = 16'h3FFF;
    localparam logic [15:0] RAM_BASE      = 16'h4000;
    localparam logic [15:0] RAM_LAST      = 16'h4FFF;
    localparam logic [15:0] ROM_BANK_BASE = 16'h6000;
    localparam logic [15:0] ROM_BANK_LAST = 16'h7FFF;
    localparam logic [15:0] ROM_FIX_BASE  = 16'h8000;

    // Banked pages start above the fixed 32kB in the ROM image
    localparam logic [17:0] ROM_BANKED_OFS = 18'h10000;
    localparam logic [ 7:0] OPEN_BUS       = 8'hFF;

    function automatic mem_region_e region_of(logic [15:0] addr);
        if (addr >= ROM_FIX_BASE)                              return rgn_rom_fix;
        else if (addr >= ROM_BANK_BASE && addr <= ROM_BANK_LAST) return rgn_rom_bank;
        else if (addr >= RAM_BASE && addr <= RAM_LAST)           return rgn_ram;
        else if (addr >= GFX2_BASE && addr <= GFX2_LAST)         return rgn_gfx2;
        else if (addr >= PAL_BASE && addr <= PAL_LAST)           return rgn_pal;
        else if (addr >= IO_BASE && addr <= IO_LAST)             return rgn_io;
        else if (addr <= GFX1_LAST)                              return rgn_gfx1;
        else                                                     return rgn_none;
    endfunction

    // Bank window: bank * 0x2000 + offset + 0x10000, fixed window: addr - 0x8000
    function automatic logic [17:0] rom_map(logic [3:0] bank, logic [15:0] addr);
        logic [17:0] page;
        logic [15:0] fix_ofs;
        page    = {1'b0, bank, 13'h0000};
        fix_ofs = addr - ROM_FIX_BASE;
        if (addr >= ROM_FIX_BASE)
            return {2'b00, fix_ofs};
        else
            return ROM_BANKED_OFS + page + {5'd0, addr[12:0]};
    endfunction

endpackage

/* logic/main_decoder.sv */
`timescale 1ns/1ps

module main_decoder
    import main_pkg::*;
#(
    parameter int RAM_AW = 12
) (
    input  logic              clk,
    input  logic              rst_n,
    // Wishbone slave
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [15:0]       wb_adr,
    input  logic [ 7:0]       wb_dat_w,
    output logic [ 7:0]       wb_dat_r,
    output logic              wb_ack,
    // ROM
    output logic              rom_cs,
    output logic [17:0]       rom_addr,
    input  logic [ 7:0]       rom_data,
    input  logic              rom_ok,
    // External chips
    output logic              gfx1_cs,
    output logic              gfx2_cs,
    output logic              pal_cs,
    input  logic [ 7:0]       gfx1_dout,
    input  logic [ 7:0]       gfx2_dout,
    input  logic [ 7:0]       pal_dout,
    output logic [15:0]       cpu_addr,
    output logic              cpu_rnw,
    output logic [ 7:0]       cpu_dout,
    // Register block
    output logic              io_rd,
    output logic              io_wr,
    output io_reg_e           io_addr,
    input  logic [ 7:0]       io_dout,
    input  logic [ 3:0]       rom_bank,
    // Work RAM
    output logic              ram_we,
    output logic [RAM_AW-1:0] ram_addr,
    input  logic [ 7:0]       ram_dout
);

    bus_state_e  state;
    mem_region_e region;
    logic        req;
    logic        is_rom;
    logic        advance;
    logic [ 7:0] rd_mux;

    assign req    = wb_cyc & wb_stb;
    assign region = region_of(wb_adr);
    assign is_rom = (region == rgn_rom_bank) || (region == rgn_rom_fix);

    // Non-ROM regions spend exactly one cycle in the wait state
    assign advance = !is_rom || rom_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            unique case (state)
                st_idle:     if (req) state <= st_rom_wait;
                st_rom_wait: if (advance) state <= st_ack;
                st_ack:      state <= st_idle;
                default:     state <= st_idle;
            endcase
        end
    end

    assign wb_ack = state == st_ack;

    always_comb begin
        unique case (region)
            rgn_gfx1:     rd_mux = gfx1_dout;
            rgn_io:       rd_mux = io_dout;
            rgn_pal:      rd_mux = pal_dout;
            rgn_gfx2:     rd_mux = gfx2_dout;
            rgn_ram:      rd_mux = ram_dout;
            rgn_rom_bank,
            rgn_rom_fix:  rd_mux = rom_data;
            default:      rd_mux = OPEN_BUS;
        endcase
    end

    // Read data captured on the edge that enters the ack state
    always_ff @(posedge clk) begin
        if (state == st_rom_wait && advance)
            wb_dat_r <= rd_mux;
    end

    // ROM
    assign rom_cs   = (state == st_rom_wait) && is_rom;
    assign rom_addr = rom_map(rom_bank, wb_adr);

    // External chip side
    assign gfx1_cs  = req && region == rgn_gfx1;
    assign gfx2_cs  = req && region == rgn_gfx2;
    assign pal_cs   = req && region == rgn_pal;
    assign cpu_addr = wb_adr;
    assign cpu_rnw  = ~wb_we;
    assign cpu_dout = wb_dat_w;

    // Writes land on the ack edge
    assign io_rd    = req && region == rgn_io && !wb_we;
    assign io_wr    = wb_ack && region == rgn_io && wb_we;
    assign io_addr  = io_reg_e'(wb_adr[2:0]);
    assign ram_we   = wb_ack && region == rgn_ram && wb_we;
    assign ram_addr = wb_adr[RAM_AW-1:0];

    a_ack_in_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_ack |-> wb_cyc && wb_stb
    ) else $error("wb_ack outside of an active request");

    a_one_cs: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({gfx1_cs, gfx2_cs, pal_cs, rom_cs})
    ) else $error("more than one chip select active");

endmodule

/* logic/main_io_regs.sv */
`timescale 1ns/1ps

module main_io_regs
    import main_pkg::*;
#(
    parameter int SND_IRQ_LEN = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        io_rd,
    input  logic        io_wr,
    input  io_reg_e     io_addr,
    input  logic [ 7:0] io_din,
    // Cabinet inputs
    input  logic [ 1:0] start_button,
    input  logic [ 1:0] coin_input,
    input  logic [ 5:0] joystick1,
    input  logic [ 5:0] joystick2,
    input  logic        service,
    input  logic [ 7:0] dipsw_a,
    input  logic [ 7:0] dipsw_b,
    input  logic [ 3:0] dipsw_c,
    output logic [ 7:0] io_dout,
    // Write registers
    output logic [ 7:0] snd_latch,
    output logic        snd_irq,
    output logic [ 7:0] video_bank,
    output logic        prio_latch,
    output logic [ 3:0] rom_bank,
    output logic        irq_en,
    output logic        irq_ack
);

    localparam int CNT_W = $clog2(SND_IRQ_LEN + 1);

    logic [CNT_W-1:0] snd_cnt;
    logic             snd_wr;

    // Cabinet inputs sampled while a read is pending
    always_ff @(posedge clk) begin
        if (io_rd) begin
            unique case (io_addr)
                reg_sys_snd:      io_dout <= {3'b111, service, start_button, coin_input};
                reg_joy1_irq:     io_dout <= {2'b11, joystick1};
                reg_joy2_vbank:   io_dout <= {2'b11, joystick2};
                reg_dipa_prio:    io_dout <= dipsw_a;
                reg_dipb_rombank: io_dout <= dipsw_b;
                reg_dipc_ack:     io_dout <= {4'hF, dipsw_c};
                default:          io_dout <= OPEN_BUS;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_latch  <= '0;
            video_bank <= '0;
            prio_latch <= 1'b0;
            irq_en     <= 1'b0;
            rom_bank   <= '0;
        end else if (io_wr) begin
            unique case (io_addr)
                reg_sys_snd:    snd_latch  <= io_din;
                reg_joy2_vbank: video_bank <= io_din;
                reg_dipa_prio: begin
                    prio_latch <= io_din[0];
                    irq_en     <= io_din[1];
                end
                reg_dipb_rombank: rom_bank <= io_din[3:0];
                default: ;
            endcase
        end
    end

    // Acknowledge is a one cycle strobe to the interrupt latch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            irq_ack <= 1'b0;
        else
            irq_ack <= io_wr && io_addr == reg_dipc_ack;
    end

    // Sound irq pulse, reloaded by every write
    assign snd_wr = io_wr && io_addr == reg_joy1_irq;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            snd_cnt <= '0;
        else if (snd_wr)
            snd_cnt <= CNT_W'(SND_IRQ_LEN);
        else if (snd_cnt != '0)
            snd_cnt <= snd_cnt - 1'b1;
    end

    assign snd_irq = snd_cnt != '0;

    a_snd_restart: assert property (
        @(posedge clk) disable iff (!rst_n)
        (snd_wr && snd_irq) |=> snd_irq [*SND_IRQ_LEN]
    ) else $error("snd_irq pulse not restarted by a second write");

endmodule

/* logic/main_irq.sv */
`timescale 1ns/1ps

module main_irq (
    input  logic clk,
    input  logic rst_n,
    input  logic gfx_irqn,
    input  logic dip_pause,
    input  logic irq_en,
    input  logic irq_ack,
    output logic irq_n
);

    logic gfx_irqn_q;
    logic trigger;

    // Falling edge of the video interrupt, held off while paused
    assign trigger = gfx_irqn_q && !gfx_irqn && dip_pause && irq_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gfx_irqn_q <= 1'b1;
            irq_n      <= 1'b1;
        end else begin
            gfx_irqn_q <= gfx_irqn;
            if (irq_ack)
                irq_n <= 1'b1;
            else if (trigger)
                irq_n <= 1'b0;
        end
    end

    a_irq_cause: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(irq_n) |-> $past(gfx_irqn, 2) && $past(!gfx_irqn && dip_pause && irq_en)
    ) else $error("irq_n fell without a qualified gfx_irqn edge");

endmodule

/* logic/main_work_ram.sv */
`timescale 1ns/1ps

module main_work_ram #(
    parameter int RAM_AW = 12
) (
    input  logic              clk,
    input  logic              ram_we,
    input  logic [RAM_AW-1:0] ram_addr,
    input  logic [ 7:0]       ram_din,
    output logic [ 7:0]       ram_dout
);

    logic [7:0] mem [2**RAM_AW];

    // Read returns the old contents on a write cycle
    always_ff @(posedge clk) begin
        if (ram_we)
            mem[ram_addr] <= ram_din;
        ram_dout <= mem[ram_addr];
    end

endmodule

/* logic/main_board.sv */
`timescale 1ns/1ps

module main_board
    import main_pkg::*;
#(
    parameter int RAM_AW      = 12,
    parameter int SND_IRQ_LEN = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    // Wishbone slave
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [15:0] wb_adr,
    input  logic [ 7:0] wb_dat_w,
    output logic [ 7:0] wb_dat_r,
    output logic        wb_ack,
    // Sound CPU
    output logic        snd_irq,
    output logic [ 7:0] snd_latch,
    // ROM
    output logic [17:0] rom_addr,
    output logic        rom_cs,
    input  logic [ 7:0] rom_data,
    input  logic        rom_ok,
    // Cabinet
    input  logic [ 1:0] start_button,
    input  logic [ 1:0] coin_input,
    input  logic [ 5:0] joystick1,
    input  logic [ 5:0] joystick2,
    input  logic        service,
    // Video chips
    output logic [15:0] cpu_addr,
    output logic        cpu_rnw,
    output logic [ 7:0] cpu_dout,
    input  logic        gfx_irqn,
    output logic        gfx1_cs,
    output logic        gfx2_cs,
    output logic        pal_cs,
    output logic [ 7:0] video_bank,
    output logic        prio_latch,
    input  logic [ 7:0] gfx1_dout,
    input  logic [ 7:0] gfx2_dout,
    input  logic [ 7:0] pal_dout,
    // DIP switches
    input  logic        dip_pause,
    input  logic [ 7:0] dipsw_a,
    input  logic [ 7:0] dipsw_b,
    input  logic [ 3:0] dipsw_c,
    output logic        irq_n
);

    logic              io_rd;
    logic              io_wr;
    io_reg_e           io_addr;
    logic [ 7:0]       io_dout;
    logic [ 3:0]       rom_bank;
    logic              irq_en;
    logic              irq_ack;
    logic              ram_we;
    logic [RAM_AW-1:0] ram_addr;
    logic [ 7:0]       ram_dout;

    main_decoder #(
        .RAM_AW     ( RAM_AW     )
    ) u_decoder (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .wb_cyc     ( wb_cyc     ),
        .wb_stb     ( wb_stb     ),
        .wb_we      ( wb_we      ),
        .wb_adr     ( wb_adr     ),
        .wb_dat_w   ( wb_dat_w   ),
        .wb_dat_r   ( wb_dat_r   ),
        .wb_ack     ( wb_ack     ),
        .rom_cs     ( rom_cs     ),
        .rom_addr   ( rom_addr   ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .gfx1_cs    ( gfx1_cs    ),
        .gfx2_cs    ( gfx2_cs    ),
        .pal_cs     ( pal_cs     ),
        .gfx1_dout  ( gfx1_dout  ),
        .gfx2_dout  ( gfx2_dout  ),
        .pal_dout   ( pal_dout   ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_rnw    ( cpu_rnw    ),
        .cpu_dout   ( cpu_dout   ),
        .io_rd      ( io_rd      ),
        .io_wr      ( io_wr      ),
        .io_addr    ( io_addr    ),
        .io_dout    ( io_dout    ),
        .rom_bank   ( rom_bank   ),
        .ram_we     ( ram_we     ),
        .ram_addr   ( ram_addr   ),
        .ram_dout   ( ram_dout   )
    );

    main_io_regs #(
        .SND_IRQ_LEN  ( SND_IRQ_LEN  )
    ) u_io (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .io_rd        ( io_rd        ),
        .io_wr        ( io_wr        ),
        .io_addr      ( io_addr      ),
        .io_din       ( wb_dat_w     ),
        .start_button ( start_button ),
        .coin_input   ( coin_input   ),
        .joystick1    ( joystick1    ),
        .joystick2    ( joystick2    ),
        .service      ( service      ),
        .dipsw_a      ( dipsw_a      ),
        .dipsw_b      ( dipsw_b      ),
        .dipsw_c      ( dipsw_c      ),
        .io_dout      ( io_dout      ),
        .snd_latch    ( snd_latch    ),
        .snd_irq      ( snd_irq      ),
        .video_bank   ( video_bank   ),
        .prio_latch   ( prio_latch   ),
        .rom_bank     ( rom_bank     ),
        .irq_en       ( irq_en       ),
        .irq_ack      ( irq_ack      )
    );

    main_irq u_irq (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .gfx_irqn   ( gfx_irqn   ),
        .dip_pause  ( dip_pause  ),
        .irq_en     ( irq_en     ),
        .irq_ack    ( irq_ack    ),
        .irq_n      ( irq_n      )
    );

    main_work_ram #(
        .RAM_AW     ( RAM_AW     )
    ) u_ram (
        .clk        ( clk        ),
        .ram_we     ( ram_we     ),
        .ram_addr   ( ram_addr   ),
        .ram_din    ( wb_dat_w   ),
        .ram_dout   ( ram_dout   )
    );

endmodule

/* verif/main_board_checker.sv */
`timescale 1ns/1ps

module main_board_checker #(
    parameter int RAM_AW      = 12,
    parameter int SND_IRQ_LEN = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [15:0] wb_adr,
    input  logic [ 7:0] wb_dat_w,
    input  logic [ 7:0] wb_dat_r,
    input  logic        wb_ack,
    input  logic [17:0] rom_addr,
    input  logic        rom_cs,
    input  logic        gfx1_cs,
    input  logic        gfx2_cs,
    input  logic        pal_cs,
    input  logic [15:0] cpu_addr,
    input  logic        cpu_rnw,
    input  logic [ 7:0] cpu_dout,
    input  logic        snd_irq,
    input  logic [ 7:0] snd_latch,
    input  logic [ 7:0] video_bank,
    input  logic        prio_latch,
    input  logic        irq_n,
    input  logic        gfx_irqn,
    input  logic        dip_pause,
    input  logic [ 1:0] start_button,
    input  logic [ 1:0] coin_input,
    input  logic [ 5:0] joystick1,
    input  logic [ 5:0] joystick2,
    input  logic        service,
    input  logic [ 7:0] dipsw_a,
    input  logic [ 7:0] dipsw_b,
    input  logic [ 3:0] dipsw_c,
    output int          errors,
    output int          checks
);

    localparam int R_GFX1 = 0;
    localparam int R_IO   = 1;
    localparam int R_PAL  = 2;
    localparam int R_GFX2 = 3;
    localparam int R_RAM  = 4;
    localparam int R_ROM  = 5;
    localparam int R_NONE = 6;

    // Shadow state of the board
    logic [7:0] ram_sh [2**RAM_AW];
    logic [7:0] snd_sh;
    logic [7:0] vbank_sh;
    logic       prio_sh;
    logic       irq_en_sh;
    logic [3:0] bank_sh;
    logic       ack_pend;
    logic       gfx_q;
    logic       exp_irq_n;
    logic       busy;
    int         cycle;
    int         start_cycle;
    int         hi_len;

    function automatic int region(input logic [15:0] a);
        if (a >= 16'h6000)                      return R_ROM;
        else if (a >= 16'h4000 && a <= 16'h4FFF) return R_RAM;
        else if (a >= 16'h2000 && a <= 16'h3FFF) return R_GFX2;
        else if (a >= 16'h1800 && a <= 16'h18FF) return R_PAL;
        else if (a >= 16'h1000 && a <= 16'h10FF) return R_IO;
        else if (a <= 16'h0FFF)                  return R_GFX1;
        else                                     return R_NONE;
    endfunction

    function automatic logic [17:0] exp_rom_addr(input logic [15:0] a);
        if (a >= 16'h8000)
            return 18'(a - 16'h8000);
        else
            return 18'h10000 + 18'(bank_sh) * 18'h2000 + 18'(a - 16'h6000);
    endfunction

    // Expected read data from the memory map and the external models
    function automatic logic [7:0] ref_read(input logic [15:0] a);
        logic [17:0] ra;
        ra = exp_rom_addr(a);
        case (region(a))
            R_GFX1: return a[7:0] ^ 8'h5A;
            R_GFX2: return a[15:8] + a[7:0];
            R_PAL:  return ~a[7:0];
            R_RAM:  return ram_sh[a[RAM_AW-1:0]];
            R_ROM:  return ra[7:0] ^ ra[15:8];
            R_IO: begin
                case (a[2:0])
                    3'd0:    return {3'b111, service, start_button, coin_input};
                    3'd1:    return {2'b11, joystick1};
                    3'd2:    return {2'b11, joystick2};
                    3'd3:    return dipsw_a;
                    3'd4:    return dipsw_b;
                    3'd5:    return {4'hF, dipsw_c};
                    default: return 8'hFF;
                endcase
            end
            default: return 8'hFF;
        endcase
    endfunction

    task automatic check(input string name, input logic [17:0] got, input logic [17:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            snd_sh    = '0;
            vbank_sh  = '0;
            prio_sh   = 1'b0;
            irq_en_sh = 1'b0;
            bank_sh   = '0;
            ack_pend  = 1'b0;
            gfx_q     = 1'b1;
            exp_irq_n = 1'b1;
            busy      = 1'b0;
            cycle     = 0;
            hi_len    = 0;
        end else begin
            cycle++;
            // Interrupt latch, using the values from before this edge
            if (ack_pend)
                exp_irq_n = 1'b1;
            else if (gfx_q && !gfx_irqn && dip_pause && irq_en_sh)
                exp_irq_n = 1'b0;
            ack_pend = 1'b0;
            gfx_q    = gfx_irqn;

            // Sound irq pulse length
            if (snd_irq) begin
                hi_len++;
            end else if (hi_len != 0) begin
                check("snd_irq pulse length", 18'(hi_len), 18'(SND_IRQ_LEN));
                hi_len = 0;
            end

            // Chip selects follow the decoded region
            check("gfx1_cs", gfx1_cs, wb_cyc && wb_stb && region(wb_adr) == R_GFX1);
            check("gfx2_cs", gfx2_cs, wb_cyc && wb_stb && region(wb_adr) == R_GFX2);
            check("pal_cs", pal_cs, wb_cyc && wb_stb && region(wb_adr) == R_PAL);
            // ROM select spans the wait between the first sampled edge and ack
            check("rom_cs", rom_cs, busy && !wb_ack && region(wb_adr) == R_ROM);
            if (wb_cyc && wb_stb) begin
                check("cpu_addr", cpu_addr, wb_adr);
                check("cpu_rnw", cpu_rnw, !wb_we);
                if (wb_we)
                    check("cpu_dout", cpu_dout, wb_dat_w);
            end

            if (wb_cyc && wb_stb && !busy) begin
                busy        = 1'b1;
                start_cycle = cycle;
            end

            if (wb_ack) begin
                if (!busy) begin
                    errors++;
                    $display("wb_ack arrived without a pending request at %0t", $time);
                end
                busy = 1'b0;
                if (region(wb_adr) != R_ROM)
                    check("ack latency", 18'(cycle - start_cycle), 18'd2);
                else
                    check("rom_addr", rom_addr, exp_rom_addr(wb_adr));
                if (!wb_we) begin
                    check("wb_dat_r", wb_dat_r, ref_read(wb_adr));
                end else if (region(wb_adr) == R_RAM) begin
                    ram_sh[wb_adr[RAM_AW-1:0]] = wb_dat_w;
                end else if (region(wb_adr) == R_IO) begin
                    case (wb_adr[2:0])
                        3'd0: snd_sh = wb_dat_w;
                        3'd2: vbank_sh = wb_dat_w;
                        3'd3: begin
                            prio_sh   = wb_dat_w[0];
                            irq_en_sh = wb_dat_w[1];
                        end
                        3'd4: bank_sh = wb_dat_w[3:0];
                        3'd5: ack_pend = 1'b1;
                        default: ;
                    endcase
                end
            end
        end
    end

    // Register outputs compared away from the clock edge
    always @(negedge clk) begin
        if (rst_n) begin
            check("snd_latch", snd_latch, snd_sh);
            check("video_bank", video_bank, vbank_sh);
            check("prio_latch", prio_latch, prio_sh);
            check("irq_n", irq_n, exp_irq_n);
        end
    end

endmodule

/* verif/main_board_tb.sv */
`timescale 1ns/1ps

module main_board_tb;

    localparam int RAM_AW      = 12;
    localparam int SND_IRQ_LEN = 8;
    localparam int TIMEOUT     = 64;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [ 7:0] wb_dat_w;
    logic [ 7:0] wb_dat_r;
    logic        wb_ack;
    logic        snd_irq;
    logic [ 7:0] snd_latch;
    logic [17:0] rom_addr;
    logic        rom_cs;
    logic [ 7:0] rom_data;
    logic        rom_ok;
    logic [ 1:0] start_button;
    logic [ 1:0] coin_input;
    logic [ 5:0] joystick1;
    logic [ 5:0] joystick2;
    logic        service;
    logic [15:0] cpu_addr;
    logic        cpu_rnw;
    logic [ 7:0] cpu_dout;
    logic        gfx_irqn;
    logic        gfx1_cs;
    logic        gfx2_cs;
    logic        pal_cs;
    logic [ 7:0] video_bank;
    logic        prio_latch;
    logic [ 7:0] gfx1_dout;
    logic [ 7:0] gfx2_dout;
    logic [ 7:0] pal_dout;
    logic        dip_pause;
    logic [ 7:0] dipsw_a;
    logic [ 7:0] dipsw_b;
    logic [ 3:0] dipsw_c;
    logic        irq_n;

    logic [15:0] lfsr;
    logic [15:0] ram_slot [16];
    int          timeouts;
    int          chk_errors;
    int          chk_checks;

    // External chip models
    assign rom_data  = rom_addr[7:0] ^ rom_addr[15:8];
    assign gfx1_dout = cpu_addr[7:0] ^ 8'h5A;
    assign gfx2_dout = cpu_addr[15:8] + cpu_addr[7:0];
    assign pal_dout  = ~cpu_addr[7:0];

    always #4 clk = ~clk;

    main_board #(
        .RAM_AW(RAM_AW),
        .SND_IRQ_LEN(SND_IRQ_LEN)
    ) u_main_board (.*);

    main_board_checker #(
        .RAM_AW(RAM_AW),
        .SND_IRQ_LEN(SND_IRQ_LEN)
    ) u_chk (
        .errors(chk_errors),
        .checks(chk_checks),
        .*
    );

    // Taps 16, 14, 13, 11
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[14:0], lfsr_bit()};
        return v;
    endfunction

    task automatic finish_run();
        int total;
        total = chk_errors + timeouts;
        $display("checks %0d, errors %0d, timeouts %0d", chk_checks, chk_errors, timeouts);
        if (total == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    endtask

    // One Wishbone cycle, also playing the ROM wait line
    task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [7:0] dat);
        int delay;
        int rom_cnt;
        int n;
        delay   = (adr >= 16'h6000) ? int'(rand_bits(3)) : 0;
        rom_cnt = 0;
        n       = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        do begin
            @(negedge clk);
            n++;
            if (rom_cs) begin
                if (rom_cnt >= delay)
                    rom_ok = 1'b1;
                rom_cnt++;
            end
            if (n > TIMEOUT) begin
                timeouts++;
                $display("Timeout waiting for wb_ack at address %h", adr);
                finish_run();
            end
        end while (!wb_ack);
        rom_ok = 1'b0;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [15:0] adr, input logic [7:0] dat);
        bus_cycle(1'b1, adr, dat);
    endtask

    task automatic bus_read(input logic [15:0] adr);
        bus_cycle(1'b0, adr, 8'h00);
    endtask

    task automatic wait_irq_n(input logic level);
        int n;
        n = 0;
        while (irq_n !== level) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                timeouts++;
                $display("Timeout waiting for irq_n to reach %b", level);
                finish_run();
            end
        end
    endtask

    task automatic wait_snd_pulse();
        int n;
        n = 0;
        while (snd_irq !== 1'b1 || n == 0) begin
            @(negedge clk);
            n++;
            if (snd_irq === 1'b1)
                break;
            if (n > TIMEOUT) begin
                timeouts++;
                $display("Timeout waiting for snd_irq to rise");
                finish_run();
            end
        end
        n = 0;
        while (snd_irq === 1'b1) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                timeouts++;
                $display("Timeout waiting for snd_irq to fall");
                finish_run();
            end
        end
        @(negedge clk);
    endtask

    task automatic gfx_pulse();
        gfx_irqn = 1'b0;
        repeat (2) @(negedge clk);
        gfx_irqn = 1'b1;
        repeat (3) @(negedge clk);
    endtask

    initial begin
        lfsr         = 16'd49061;
        timeouts     = 0;
        clk          = 1'b0;
        rst_n        = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        rom_ok       = 1'b0;
        start_button = 2'b10;
        coin_input   = 2'b01;
        joystick1    = 6'h2A;
        joystick2    = 6'h15;
        service      = 1'b1;
        gfx_irqn     = 1'b1;
        dip_pause    = 1'b1;
        dipsw_a      = 8'hA5;
        dipsw_b      = 8'h3C;
        dipsw_c      = 4'h9;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Work RAM, every slot written before random traffic
        for (int k = 0; k < 16; k++) begin
            ram_slot[k] = {4'h4, 4'(k), 8'(rand_bits(8))};
            bus_write(ram_slot[k], rand_bits(8));
        end
        for (int i = 0; i < 48; i++) begin
            if (rand_bits(1))
                bus_write(ram_slot[rand_bits(4)], rand_bits(8));
            else
                bus_read(ram_slot[rand_bits(4)]);
        end

        // I/O window and unmapped space
        for (int k = 0; k < 8; k++)
            bus_read(16'h1000 + 16'(k));
        bus_read(16'h10F9);
        bus_read(16'h1400);
        bus_read(16'h1F00);
        bus_read(16'h5123);
        bus_write(16'h1000, rand_bits(8));
        bus_write(16'h1002, rand_bits(8));
        bus_write(16'h1003, 8'h01);

        // Sound latch and irq pulse
        bus_write(16'h1000, 8'hC3);
        bus_write(16'h1001, 8'h00);
        wait_snd_pulse();

        // ROM in both windows with random banks
        for (int i = 0; i < 12; i++) begin
            bus_write(16'h1004, rand_bits(8));
            bus_read({1'b1, 15'(rand_bits(15))});
            bus_read({3'b011, 13'(rand_bits(13))});
        end

        // Vertical blank interrupt gating
        bus_write(16'h1003, 8'h00);
        gfx_pulse();
        bus_write(16'h1003, 8'h02);
        dip_pause = 1'b0;
        gfx_pulse();
        dip_pause = 1'b1;
        gfx_pulse();
        wait_irq_n(1'b0);
        bus_write(16'h1005, 8'h00);
        wait_irq_n(1'b1);

        // Graphics chips and palette
        for (int i = 0; i < 8; i++) begin
            bus_read({4'h0, 12'(rand_bits(12))});
            bus_write({4'h0, 12'(rand_bits(12))}, rand_bits(8));
            bus_read({3'b001, 13'(rand_bits(13))});
            bus_write({3'b001, 13'(rand_bits(13))}, rand_bits(8));
            bus_read({8'h18, 8'(rand_bits(8))});
            bus_write({8'h18, 8'(rand_bits(8))}, rand_bits(8));
        end

        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

/* src.f */
logic/main_pkg.sv
logic/main_decoder.sv
logic/main_io_regs.sv
logic/main_irq.sv
logic/main_work_ram.sv
logic/main_board.sv
verif/main_board_checker.sv
verif/main_board_tb.sv
